//--- hw/pipe_ctrl_pkg.sv
// pipeline control package
// shared address type and the select encodings passed between the
// control unit and the fetch pc unit
`default_nettype none

package pipe_ctrl_pkg;

    // instruction address
    typedef logic [31:0] addr_t;

    // next pc source for the fetch stage
    typedef enum logic [1:0] {
        NEXT_PC_SEL_BP_OR_PC_4 = 2'b00,
        NEXT_PC_SEL_KEEP_PC    = 2'b01,
        NEXT_PC_SEL_JUMP       = 2'b10,
        NEXT_PC_SEL_DEBUG      = 2'b11
    } next_pc_sel_t;

    // which jump target feeds the fetch address on a jump
    typedef enum logic [1:0] {
        SEL_JUMP_DECODE    = 2'b00,
        SEL_JUMP_EXECUTION = 2'b01,
        SEL_JUMP_CSR       = 2'b10,
        SEL_JUMP_DEBUG     = 2'b11
    } sel_addr_if_t;

endpackage

`default_nettype wire

//--- hw/control_unit.sv
// pipeline control unit
// resolves hazard, branch, exception, fence and debug requests into
// stage stalls, stage flushes, the next pc selection and the commit
// write enable. an exception or eret is registered for one cycle so
// the csr target is taken on the following cycle
`timescale 1ns/1ps
`default_nettype none

module control_unit import pipe_ctrl_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         valid_fetch_i,
    input  logic         exe_valid_i,
    input  logic         wb_valid_i,
    input  logic         id_valid_jal_i,
    input  logic         id_stall_csr_fence_i,
    input  logic         rr_stall_csr_fence_i,
    input  logic         exe_mispredict_i,
    input  logic         exe_stall_i,
    input  logic         exe_stall_csr_fence_i,
    input  logic         wb_xcpt_i,
    input  logic         wb_ecall_i,
    input  logic         wb_fence_i,
    input  logic         wb_fence_i_i,
    input  logic         wb_write_enable_i,
    input  logic         wb_stall_csr_fence_i,
    input  logic         csr_eret_i,
    input  logic         csr_exception_i,
    input  logic         csr_stall_i,
    input  logic         debug_halt_i,
    input  logic         debug_change_pc_i,
    input  logic         debug_wr_valid_i,
    output logic         stall_if_o,
    output logic         stall_id_o,
    output logic         stall_rr_o,
    output logic         stall_exe_o,
    output logic         flush_if_o,
    output logic         flush_id_o,
    output logic         flush_rr_o,
    output logic         flush_exe_o,
    output next_pc_sel_t next_pc_o,
    output sel_addr_if_t sel_addr_if_o,
    output logic         invalidate_icache_o,
    output logic         invalidate_buffer_o,
    output logic         rf_we_o
);

    logic stall_any;
    logic mispredict;
    logic jump_enable;
    logic csr_fence_wait;
    logic wb_exception;
    logic wb_fence_valid;
    logic debug_jump;
    logic exception_d;
    logic exception_q;

    assign stall_any      = csr_stall_i || exe_stall_i;
    assign mispredict     = exe_valid_i && exe_mispredict_i;
    assign jump_enable    = mispredict || id_valid_jal_i;
    assign csr_fence_wait = id_stall_csr_fence_i || rr_stall_csr_fence_i ||
                            exe_stall_csr_fence_i || wb_stall_csr_fence_i;
    assign wb_exception   = wb_valid_i && wb_xcpt_i;
    assign wb_fence_valid = wb_valid_i && wb_fence_i;
    assign debug_jump     = debug_change_pc_i && debug_halt_i;

    // one cycle pulse, never retriggers while already set
    assign exception_d = exception_q ? 1'b0 :
                         (wb_exception || (wb_valid_i && wb_ecall_i) ||
                          csr_eret_i || csr_exception_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exception_q <= 1'b0;
        end else begin
            exception_q <= exception_d;
        end
    end

    // stalls, wb is never stalled
    always_comb begin
        stall_if_o  = 1'b0;
        stall_id_o  = 1'b0;
        stall_rr_o  = 1'b0;
        stall_exe_o = 1'b0;
        if (stall_any) begin
            stall_if_o  = 1'b1;
            stall_id_o  = 1'b1;
            stall_rr_o  = 1'b1;
            stall_exe_o = 1'b1;
        end else if (wb_valid_i && wb_stall_csr_fence_i) begin
            stall_if_o  = 1'b1;
        end
    end

    // flushes, highest priority first
    always_comb begin
        flush_if_o  = 1'b0;
        flush_id_o  = 1'b0;
        flush_rr_o  = 1'b0;
        flush_exe_o = 1'b0;
        if (wb_exception || exception_q) begin
            flush_if_o  = 1'b1;
            flush_id_o  = 1'b1;
            flush_rr_o  = 1'b1;
            flush_exe_o = 1'b1;
        end else if (mispredict) begin
            flush_if_o  = 1'b1;
            flush_id_o  = 1'b1;
            // a stalled exe keeps the instruction in rr as well
            flush_rr_o  = !exe_stall_i;
        end else if ((csr_fence_wait || id_valid_jal_i || wb_fence_valid) && !stall_any) begin
            flush_if_o  = 1'b1;
        end
    end

    always_comb begin
        if (debug_jump) begin
            next_pc_o = NEXT_PC_SEL_DEBUG;
        end else if (jump_enable || exception_q) begin
            next_pc_o = NEXT_PC_SEL_JUMP;
        end else if (!valid_fetch_i || stall_if_o || csr_fence_wait ||
                     wb_fence_valid || debug_halt_i) begin
            next_pc_o = NEXT_PC_SEL_KEEP_PC;
        end else begin
            next_pc_o = NEXT_PC_SEL_BP_OR_PC_4;
        end
    end

    // exception target wins over a branch, a branch over a jal
    always_comb begin
        if (exception_q) begin
            sel_addr_if_o = SEL_JUMP_CSR;
        end else if (mispredict) begin
            sel_addr_if_o = SEL_JUMP_EXECUTION;
        end else if (debug_jump) begin
            sel_addr_if_o = SEL_JUMP_DEBUG;
        end else begin
            sel_addr_if_o = SEL_JUMP_DECODE;
        end
    end

    // fence.i may follow self modifying code
    assign invalidate_icache_o = wb_valid_i && wb_fence_i_i;
    assign invalidate_buffer_o = wb_valid_i &&
                                 (wb_fence_i_i || exception_q ||
                                  (wb_stall_csr_fence_i && !wb_fence_i));

    // regular commits are blocked by any exception in wb
    assign rf_we_o = (debug_wr_valid_i && debug_halt_i) ||
                     (wb_valid_i && !wb_xcpt_i && !csr_exception_i && wb_write_enable_i);

endmodule

`default_nettype wire

//--- hw/fetch_pc_unit.sv
// fetch pc unit
// program counter register, updated every cycle from the next pc
// selection of the control unit
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit import pipe_ctrl_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0100
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  next_pc_sel_t next_pc_i,
    input  sel_addr_if_t sel_addr_if_i,
    input  addr_t        id_target_i,
    input  addr_t        exe_target_i,
    input  addr_t        csr_target_i,
    input  addr_t        debug_pc_i,
    output addr_t        pc_o
);

    addr_t jump_target;
    addr_t pc_d;

    always_comb begin
        case (sel_addr_if_i)
            SEL_JUMP_DECODE:    jump_target = id_target_i;
            SEL_JUMP_EXECUTION: jump_target = exe_target_i;
            SEL_JUMP_CSR:       jump_target = csr_target_i;
            default:            jump_target = debug_pc_i;
        endcase
    end

    // no predictor, so the predicted path is always pc + 4
    always_comb begin
        case (next_pc_i)
            NEXT_PC_SEL_DEBUG:   pc_d = debug_pc_i;
            NEXT_PC_SEL_JUMP:    pc_d = jump_target;
            NEXT_PC_SEL_KEEP_PC: pc_d = pc_o;
            default:             pc_d = pc_o + 32'd4;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_o <= RESET_PC;
        end else begin
            pc_o <= pc_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/stage_valid_chain.sv
// stage valid chain
// tracks which of id, rr, exe and wb hold a live instruction
// flush clears a stage, stall holds it and sends a bubble downstream
`timescale 1ns/1ps
`default_nettype none

module stage_valid_chain (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic valid_fetch_i,
    input  logic stall_if_i,
    input  logic stall_id_i,
    input  logic stall_rr_i,
    input  logic stall_exe_i,
    input  logic flush_if_i,
    input  logic flush_id_i,
    input  logic flush_rr_i,
    input  logic flush_exe_i,
    output logic id_valid_o,
    output logic rr_valid_o,
    output logic exe_valid_o,
    output logic wb_valid_o
);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            id_valid_o  <= 1'b0;
            rr_valid_o  <= 1'b0;
            exe_valid_o <= 1'b0;
            wb_valid_o  <= 1'b0;
        end else begin
            if (flush_id_i) begin
                id_valid_o <= 1'b0;
            end else if (!stall_id_i) begin
                id_valid_o <= valid_fetch_i && !stall_if_i && !flush_if_i;
            end
            if (flush_rr_i) begin
                rr_valid_o <= 1'b0;
            end else if (!stall_rr_i) begin
                rr_valid_o <= id_valid_o && !stall_id_i && !flush_id_i;
            end
            if (flush_exe_i) begin
                exe_valid_o <= 1'b0;
            end else if (!stall_exe_i) begin
                exe_valid_o <= rr_valid_o && !stall_rr_i && !flush_rr_i;
            end
            // wb always advances
            wb_valid_o <= exe_valid_o && !stall_exe_i && !flush_exe_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/pipe_ctrl_top.sv
// pipeline control slice top level
// connects the control unit, the fetch pc unit and the stage valid chain
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top import pipe_ctrl_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0100
) (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  valid_fetch_i,
    input  logic  id_valid_jal_i,
    input  logic  id_stall_csr_fence_i,
    input  logic  rr_stall_csr_fence_i,
    input  logic  exe_mispredict_i,
    input  logic  exe_stall_i,
    input  logic  exe_stall_csr_fence_i,
    input  logic  wb_xcpt_i,
    input  logic  wb_ecall_i,
    input  logic  wb_fence_i,
    input  logic  wb_fence_i_i,
    input  logic  wb_write_enable_i,
    input  logic  wb_stall_csr_fence_i,
    input  logic  csr_eret_i,
    input  logic  csr_exception_i,
    input  logic  csr_stall_i,
    input  logic  debug_halt_i,
    input  logic  debug_change_pc_i,
    input  logic  debug_wr_valid_i,
    input  addr_t debug_pc_i,
    input  addr_t id_target_i,
    input  addr_t exe_target_i,
    input  addr_t csr_target_i,
    output addr_t pc_o,
    output logic  id_valid_o,
    output logic  rr_valid_o,
    output logic  exe_valid_o,
    output logic  wb_valid_o,
    output logic  stall_if_o,
    output logic  stall_id_o,
    output logic  stall_rr_o,
    output logic  stall_exe_o,
    output logic  flush_if_o,
    output logic  flush_id_o,
    output logic  flush_rr_o,
    output logic  flush_exe_o,
    output logic  invalidate_icache_o,
    output logic  invalidate_buffer_o,
    output logic  rf_we_o
);

    next_pc_sel_t next_pc;
    sel_addr_if_t sel_addr_if;

    control_unit control_unit_i (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .valid_fetch_i         (valid_fetch_i),
        .exe_valid_i           (exe_valid_o),
        .wb_valid_i            (wb_valid_o),
        .id_valid_jal_i        (id_valid_jal_i),
        .id_stall_csr_fence_i  (id_stall_csr_fence_i),
        .rr_stall_csr_fence_i  (rr_stall_csr_fence_i),
        .exe_mispredict_i      (exe_mispredict_i),
        .exe_stall_i           (exe_stall_i),
        .exe_stall_csr_fence_i (exe_stall_csr_fence_i),
        .wb_xcpt_i             (wb_xcpt_i),
        .wb_ecall_i            (wb_ecall_i),
        .wb_fence_i            (wb_fence_i),
        .wb_fence_i_i          (wb_fence_i_i),
        .wb_write_enable_i     (wb_write_enable_i),
        .wb_stall_csr_fence_i  (wb_stall_csr_fence_i),
        .csr_eret_i            (csr_eret_i),
        .csr_exception_i       (csr_exception_i),
        .csr_stall_i           (csr_stall_i),
        .debug_halt_i          (debug_halt_i),
        .debug_change_pc_i     (debug_change_pc_i),
        .debug_wr_valid_i      (debug_wr_valid_i),
        .stall_if_o            (stall_if_o),
        .stall_id_o            (stall_id_o),
        .stall_rr_o            (stall_rr_o),
        .stall_exe_o           (stall_exe_o),
        .flush_if_o            (flush_if_o),
        .flush_id_o            (flush_id_o),
        .flush_rr_o            (flush_rr_o),
        .flush_exe_o           (flush_exe_o),
        .next_pc_o             (next_pc),
        .sel_addr_if_o         (sel_addr_if),
        .invalidate_icache_o   (invalidate_icache_o),
        .invalidate_buffer_o   (invalidate_buffer_o),
        .rf_we_o               (rf_we_o)
    );

    fetch_pc_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_pc_unit_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .next_pc_i     (next_pc),
        .sel_addr_if_i (sel_addr_if),
        .id_target_i   (id_target_i),
        .exe_target_i  (exe_target_i),
        .csr_target_i  (csr_target_i),
        .debug_pc_i    (debug_pc_i),
        .pc_o          (pc_o)
    );

    // valid bits feed back into the control unit through the outputs
    stage_valid_chain stage_valid_chain_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_fetch_i (valid_fetch_i),
        .stall_if_i    (stall_if_o),
        .stall_id_i    (stall_id_o),
        .stall_rr_i    (stall_rr_o),
        .stall_exe_i   (stall_exe_o),
        .flush_if_i    (flush_if_o),
        .flush_id_i    (flush_id_o),
        .flush_rr_i    (flush_rr_o),
        .flush_exe_i   (flush_exe_o),
        .id_valid_o    (id_valid_o),
        .rr_valid_o    (rr_valid_o),
        .exe_valid_o   (exe_valid_o),
        .wb_valid_o    (wb_valid_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and reset generator
// free running clock, active low reset released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/pipe_ctrl_assert.sv
// control unit assertions
// exception pulse width, flush ordering and stall ordering
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic exception_q_i,
    input logic stall_if_i,
    input logic stall_exe_i,
    input logic flush_if_i,
    input logic flush_id_i,
    input logic flush_rr_i,
    input logic flush_exe_i
);

    // the exception pulse lasts a single cycle
    a_xcpt_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        exception_q_i |=> !exception_q_i)
        else $error("exception pulse high for two cycles");

    // only an exception reaches exe, and it clears every younger stage too
    a_exe_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_exe_i |-> (flush_if_i && flush_id_i && flush_rr_i))
        else $error("exe flushed without the younger stages");

    a_stall_order: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stall_exe_i |-> stall_if_i)
        else $error("exe stalled while fetch runs");

endmodule

bind control_unit pipe_ctrl_assert assert_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .exception_q_i (exception_q),
    .stall_if_i    (stall_if_o),
    .stall_exe_i   (stall_exe_o),
    .flush_if_i    (flush_if_o),
    .flush_id_i    (flush_id_o),
    .flush_rr_i    (flush_rr_o),
    .flush_exe_i   (flush_exe_o)
);

`default_nettype wire

//--- verification/pipe_ctrl_tb.sv
// pipeline control slice testbench
// reads per cycle vectors, drives the DUT on the falling edge and checks
// pc, valid, stall, flush and commit outputs against the expected columns
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb import pipe_ctrl_pkg::*; ();

    localparam int PERIOD_NS = 8;
    // outputs settle well before the rising edge that consumes the inputs
    localparam int CHECK_DELAY = 3;

    logic clk;
    logic rstn;
    logic valid_fetch, id_jal, id_csrf, rr_csrf, exe_mp, exe_stall, exe_csrf;
    logic wb_xcpt, wb_ecall, wb_fence, wb_fence_i, wb_we, wb_csrf;
    logic csr_eret, csr_exc, csr_stall, dbg_halt, dbg_change, dbg_wr;
    addr_t pc;
    logic id_v, rr_v, exe_v, wb_v;
    logic st_if, st_id, st_rr, st_exe, fl_if, fl_id, fl_rr, fl_exe;
    logic inv_icache, inv_buffer, rf_we;

    logic [18:0] in_q[$];
    logic [31:0] pc_q[$];
    logic [14:0] exp_q[$];
    string       name_q[$];
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          timeout_limit = 1000;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) clock_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    pipe_ctrl_top #(.RESET_PC(32'h0000_0100)) dut_i (
        .clk_i (clk), .rstn_i (rstn), .valid_fetch_i (valid_fetch),
        .id_valid_jal_i (id_jal), .id_stall_csr_fence_i (id_csrf),
        .rr_stall_csr_fence_i (rr_csrf), .exe_mispredict_i (exe_mp),
        .exe_stall_i (exe_stall), .exe_stall_csr_fence_i (exe_csrf),
        .wb_xcpt_i (wb_xcpt), .wb_ecall_i (wb_ecall), .wb_fence_i (wb_fence),
        .wb_fence_i_i (wb_fence_i), .wb_write_enable_i (wb_we),
        .wb_stall_csr_fence_i (wb_csrf), .csr_eret_i (csr_eret),
        .csr_exception_i (csr_exc), .csr_stall_i (csr_stall),
        .debug_halt_i (dbg_halt), .debug_change_pc_i (dbg_change),
        .debug_wr_valid_i (dbg_wr), .debug_pc_i (32'h0000_0500),
        .id_target_i (32'h0000_0200), .exe_target_i (32'h0000_0300),
        .csr_target_i (32'h0000_0400), .pc_o (pc),
        .id_valid_o (id_v), .rr_valid_o (rr_v), .exe_valid_o (exe_v), .wb_valid_o (wb_v),
        .stall_if_o (st_if), .stall_id_o (st_id), .stall_rr_o (st_rr), .stall_exe_o (st_exe),
        .flush_if_o (fl_if), .flush_id_o (fl_id), .flush_rr_o (fl_rr), .flush_exe_o (fl_exe),
        .invalidate_icache_o (inv_icache), .invalidate_buffer_o (inv_buffer),
        .rf_we_o (rf_we)
    );

    // bit order matches the input columns of the vector file
    task automatic apply_inputs(input logic [18:0] v);
        {valid_fetch, id_jal, id_csrf, rr_csrf, exe_mp, exe_stall, exe_csrf} = v[18:12];
        {wb_xcpt, wb_ecall, wb_fence, wb_fence_i, wb_we, wb_csrf} = v[11:6];
        {csr_eret, csr_exc, csr_stall, dbg_halt, dbg_change, dbg_wr} = v[5:0];
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_vectors();
        int fd;
        int n;
        string line;
        logic [31:0] f_vf, f_id, f_rr, f_exe, f_wb, f_csr, f_dbg;
        logic [31:0] f_pc, f_v, f_s, f_f, f_m;
        fd = $fopen("verification/pipe_ctrl_input.txt", "r");
        if (fd == 0) begin
            $display("vector file verification/pipe_ctrl_input.txt could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0a ||
                                      line.getc(line.len() - 1) == 8'h0d)) begin
                line = line.substr(0, line.len() - 2);
            end
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            if (line.len() > 4 && line.substr(0, 2) == "end") begin
                if (name_q.size() > 0) begin
                    name_q[name_q.size() - 1] = line.substr(4, line.len() - 1);
                end
                continue;
            end
            n = $sscanf(line, "%b %b %b %b %b %b %b %h %b %b %b %b", f_vf, f_id, f_rr,
                        f_exe, f_wb, f_csr, f_dbg, f_pc, f_v, f_s, f_f, f_m);
            if (n != 12) begin
                $display("vector line could not be parsed: %s", line);
                errors++;
                continue;
            end
            in_q.push_back({f_vf[0], f_id[1:0], f_rr[0], f_exe[2:0], f_wb[5:0],
                            f_csr[2:0], f_dbg[2:0]});
            pc_q.push_back(f_pc);
            exp_q.push_back({f_v[3:0], f_s[3:0], f_f[3:0], f_m[2:0]});
            name_q.push_back("");
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, the vectors did not complete", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int test_count;
        int test_errors;
        test_count = 0;
        test_errors = 0;
        apply_inputs('0);
        read_vectors();
        timeout_limit = in_q.size() + 50;
        wait (rstn == 1'b1);
        for (int i = 0; i < in_q.size(); i++) begin
            @(negedge clk);
            apply_inputs(in_q[i]);
            #(CHECK_DELAY);
            compare_value($sformatf("vector %0d pc", i), pc, pc_q[i]);
            compare_value($sformatf("vector %0d valid", i), {28'd0, id_v, rr_v, exe_v, wb_v},
                          {28'd0, exp_q[i][14:11]});
            compare_value($sformatf("vector %0d stall", i),
                          {28'd0, st_if, st_id, st_rr, st_exe}, {28'd0, exp_q[i][10:7]});
            compare_value($sformatf("vector %0d flush", i),
                          {28'd0, fl_if, fl_id, fl_rr, fl_exe}, {28'd0, exp_q[i][6:3]});
            compare_value($sformatf("vector %0d icache buffer rf_we", i),
                          {29'd0, inv_icache, inv_buffer, rf_we}, {29'd0, exp_q[i][2:0]});
            if (name_q[i] != "") begin
                test_count++;
                $display("test %s done, %0d errors", name_q[i], errors - test_errors);
                test_errors = errors;
            end
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/pipe_ctrl_input.txt
# inputs: fetch | id jal,csrf | rr csrf | exe mp,stall,csrf | wb xcpt,ecall,fence,fence_i,we,csrf
#         | csr eret,exc,stall | dbg halt,change,wr
# expected: pc | valid id,rr,exe,wb | stall if..exe | flush if..exe | icache,buffer,rf_we
1 00 0 000 000000 000 000 00000100 0000 0000 0000 000
1 00 0 000 000000 000 000 00000104 1000 0000 0000 000
1 00 0 000 000000 000 000 00000108 1100 0000 0000 000
1 00 0 000 000000 000 000 0000010c 1110 0000 0000 000
1 00 0 000 000000 000 000 00000110 1111 0000 0000 000
end sequential_fetch
1 00 0 100 000000 000 000 00000114 1111 0000 1110 000
1 00 0 000 000000 000 000 00000300 0001 0000 0000 000
1 00 0 000 000000 000 000 00000304 1000 0000 0000 000
1 00 0 000 000000 000 000 00000308 1100 0000 0000 000
1 00 0 110 000000 000 000 0000030c 1110 1111 1100 000
1 00 0 000 000000 000 000 00000300 0110 0000 0000 000
end mispredict
1 10 0 000 000000 000 000 00000304 1011 0000 1000 000
1 00 0 000 001100 000 000 00000200 0101 0000 1000 110
1 00 0 000 000000 000 000 00000200 0010 0000 0000 000
end jal_fence
1 00 0 000 100010 000 000 00000204 1001 0000 1111 000
1 00 0 000 000000 000 000 00000208 0000 0000 1111 000
1 00 0 000 000000 000 000 00000400 0000 0000 0000 000
1 00 0 000 000000 100 000 00000404 1000 0000 0000 000
1 00 0 000 000000 000 000 00000408 1100 0000 1111 000
1 00 0 000 000000 000 000 00000400 0000 0000 0000 000
end exception
1 00 0 000 000000 000 000 00000404 1000 0000 0000 000
1 00 0 000 000000 000 000 00000408 1100 0000 0000 000
1 00 0 000 000000 000 000 0000040c 1110 0000 0000 000
1 00 0 000 000010 001 000 00000410 1111 1111 0000 001
1 00 0 000 000000 001 000 00000410 1110 1111 0000 000
1 00 0 000 000000 000 000 00000410 1110 0000 0000 000
end csr_stall
1 00 0 000 000000 000 100 00000414 1111 0000 0000 000
1 00 0 000 000000 000 110 00000414 1111 0000 0000 000
1 00 0 000 000000 000 101 00000500 1111 0000 0000 001
0 00 0 000 000000 000 000 00000500 1111 0000 0000 000
end debug

//--- files.f
hw/pipe_ctrl_pkg.sv
hw/control_unit.sv
hw/fetch_pc_unit.sv
hw/stage_valid_chain.sv
hw/pipe_ctrl_top.sv
verification/tb_clock_gen.sv
verification/pipe_ctrl_assert.sv
verification/pipe_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pipe_ctrl_tb \
    -f files.f -o sim_pipe_ctrl
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_pipe_ctrl)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
